/* Bender.yml */
package:
  name: rvv_backend

sources:
  - common/rvv_pkg.sv
  - common/queue_rd_if.sv
  - hdl/multi_port_fifo.sv
  - hdl/rvv_decode.sv
  - dispatch/rvv_dispatch.sv
  - hdl/rvv_vrf.sv
  - hdl/rvv_alu.sv
  - hdl/rvv_backend.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_rvv_backend.sv

/* common/queue_rd_if.sv */
`timescale 1ns/1ps

interface queue_rd_if #(
    parameter type payload_t = logic
);

    payload_t data0;
    payload_t data1;
    logic     pop0;
    logic     pop1;
    logic     empty;
    logic     one_left;

    modport fifo (
        output data0, data1, empty, one_left,
        input  pop0, pop1
    );

    modport consumer (
        input  data0, data1, empty, one_left,
        output pop0, pop1
    );

endinterface

/* common/rvv_pkg.sv */
package rvv_pkg;

    localparam int issue_lanes = 2;
    localparam int vlen        = 128;
    localparam int sew         = 8;
    localparam int num_elem    = vlen / sew;
    localparam int num_vreg    = 32;

    localparam int cq_depth = 8;
    localparam int uq_depth = 8;
    localparam int rs_depth = 4;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [vlen-1:0] vreg_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } cmd_t;

    // Instruction word fields
    localparam int funct6_msb = 31;
    localparam int funct6_lsb = 26;
    localparam int vs2_msb    = 24;
    localparam int vs2_lsb    = 20;
    localparam int vs1_msb    = 19;
    localparam int vs1_lsb    = 15;
    localparam int funct3_msb = 14;
    localparam int funct3_lsb = 12;
    localparam int vd_msb     = 11;
    localparam int vd_lsb     = 7;
    localparam int opcode_msb = 6;
    localparam int opcode_lsb = 0;

    localparam logic [6:0] opcode_vec  = 7'b1010111;
    localparam logic [2:0] funct3_opivv = 3'b000;

    localparam logic [5:0] funct6_add = 6'b000000;
    localparam logic [5:0] funct6_sub = 6'b000010;
    localparam logic [5:0] funct6_and = 6'b001001;
    localparam logic [5:0] funct6_or  = 6'b001010;
    localparam logic [5:0] funct6_xor = 6'b001011;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     op;
        reg_idx_t    vd;
        reg_idx_t    vs1;
        reg_idx_t    vs2;
        logic        illegal;
    } uop_t;

    typedef struct packed {
        uop_t  uop;
        vreg_t vs1_data;
        vreg_t vs2_data;
    } rs_uop_t;

    // Reset contents: byte j of register i is 16*i + j
    function automatic vreg_t vrf_init(input int idx);
        vreg_t v;
        for (int j = 0; j < num_elem; j++) begin
            v[j*sew +: sew] = sew'((num_elem * idx + j) % 256);
        end
        return v;
    endfunction

endpackage

/* dispatch/rvv_dispatch.sv */
`timescale 1ns/1ps

module rvv_dispatch (
    input  logic                        clk,
    input  logic                        rst_n,
    queue_rd_if.consumer                uq,
    output rvv_pkg::reg_idx_t [3:0]     rd_idx,
    input  rvv_pkg::vreg_t    [3:0]     rd_data,
    input  logic                        rs_free0,
    input  logic                        rs_free1,
    output logic                        rs_push0,
    output logic                        rs_push1,
    output rvv_pkg::rs_uop_t            rs_data0,
    output rvv_pkg::rs_uop_t            rs_data1,
    input  logic [1:0]                  wb_valid,
    input  rvv_pkg::reg_idx_t [1:0]     wb_vd
);

    logic [rvv_pkg::num_vreg-1:0] pending;
    logic [rvv_pkg::num_vreg-1:0] pending_nxt;
    rvv_pkg::uop_t                u0;
    rvv_pkg::uop_t                u1;
    logic                         hazard0;
    logic                         hazard1;
    logic                         dep1;
    logic                         issue0;
    logic                         issue1;

    assign u0 = uq.data0;
    assign u1 = uq.data1;

    assign rd_idx[0] = u0.vs1;
    assign rd_idx[1] = u0.vs2;
    assign rd_idx[2] = u1.vs1;
    assign rd_idx[3] = u1.vs2;

    assign hazard0 = pending[u0.vs1] | pending[u0.vs2] | pending[u0.vd];
    assign hazard1 = pending[u1.vs1] | pending[u1.vs2] | pending[u1.vd];

    // Lane 1 cannot see the result lane 0 is about to produce
    assign dep1 = !u0.illegal
        && ((u1.vs1 == u0.vd) || (u1.vs2 == u0.vd) || (u1.vd == u0.vd));

    assign issue0 = !uq.empty && !hazard0 && rs_free0;
    assign issue1 = issue0 && !uq.one_left && !hazard1 && !dep1 && rs_free1;

    assign uq.pop0 = issue0;
    assign uq.pop1 = issue1;
    assign rs_push0 = issue0;
    assign rs_push1 = issue1;

    assign rs_data0 = '{uop: u0, vs1_data: rd_data[0], vs2_data: rd_data[1]};
    assign rs_data1 = '{uop: u1, vs1_data: rd_data[2], vs2_data: rd_data[3]};

    always_comb begin
        pending_nxt = pending;
        for (int w = 0; w < rvv_pkg::issue_lanes; w++) begin
            if (wb_valid[w]) begin
                pending_nxt[wb_vd[w]] = 1'b0;
            end
        end
        if (issue0 && !u0.illegal) begin
            pending_nxt[u0.vd] = 1'b1;
        end
        if (issue1 && !u1.illegal) begin
            pending_nxt[u1.vd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

    // A second writer to one register would find its bit already cleared
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid[0] |-> pending[wb_vd[0]]) and (wb_valid[1] |-> pending[wb_vd[1]]));

endmodule

/* hdl/multi_port_fifo.sv */
`timescale 1ns/1ps

module multi_port_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push0,
    input  logic        push1,
    input  payload_t    data0,
    input  payload_t    data1,
    output logic        free0,
    output logic        free1,
    queue_rd_if.fifo    rd
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_nxt;
    logic [1:0]         n_push;
    logic [1:0]         n_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p, input int n);
        int sum;
        sum = int'(p) + n;
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return ptr_w'(sum);
    endfunction

    assign n_push    = {1'b0, push0} + {1'b0, push1};
    assign n_pop     = {1'b0, rd.pop0} + {1'b0, rd.pop1};
    assign count_nxt = count + cnt_w'(n_push) - cnt_w'(n_pop);

    // Status flags straight from the occupancy
    assign rd.empty    = (count == '0);
    assign rd.one_left = (count <= cnt_w'(1));

    assign rd.data0 = mem[rd_ptr];
    assign rd.data1 = mem[ptr_inc(rd_ptr, 1)];

    always_ff @(posedge clk) begin
        if (push0) begin
            mem[wr_ptr] <= data0;
        end
        if (push1) begin
            mem[ptr_inc(wr_ptr, 1)] <= data1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            free0  <= 1'b0;
            free1  <= 1'b0;
        end else begin
            wr_ptr <= ptr_inc(wr_ptr, int'(n_push));
            rd_ptr <= ptr_inc(rd_ptr, int'(n_pop));
            count  <= count_nxt;
            // Write-side flags track the next occupancy
            free0  <= (count_nxt < cnt_w'(depth));
            free1  <= (count_nxt < cnt_w'(depth - 1));
        end
    end

    // Producer must respect the free flags, lane 1 only with lane 0
    assert property (@(posedge clk) disable iff (!rst_n)
        (push0 |-> free0) and (push1 |-> push0 && free1));

    // Consumer never pops more than is stored
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd.pop0 |-> !rd.empty) and (rd.pop1 |-> rd.pop0 && !rd.one_left));

endmodule

/* hdl/rvv_alu.sv */
`timescale 1ns/1ps

module rvv_alu (
    input  logic                        clk,
    input  logic                        rst_n,
    queue_rd_if.consumer                rs,
    output logic [1:0]                  wb_valid,
    output logic [1:0][31:0]            wb_pc,
    output rvv_pkg::reg_idx_t [1:0]     wb_vd,
    output rvv_pkg::vreg_t    [1:0]     wb_data,
    output logic [1:0]                  wb_illegal
);

    rvv_pkg::rs_uop_t lane_uop [2];
    logic [1:0]       pop;

    function automatic rvv_pkg::vreg_t alu_calc(
        input rvv_pkg::alu_op_e op,
        input rvv_pkg::vreg_t   vs1,
        input rvv_pkg::vreg_t   vs2
    );
        rvv_pkg::vreg_t       res;
        logic [rvv_pkg::sew-1:0] a;
        logic [rvv_pkg::sew-1:0] b;
        for (int e = 0; e < rvv_pkg::num_elem; e++) begin
            a = vs1[e*rvv_pkg::sew +: rvv_pkg::sew];
            b = vs2[e*rvv_pkg::sew +: rvv_pkg::sew];
            case (op)
                rvv_pkg::op_sub: res[e*rvv_pkg::sew +: rvv_pkg::sew] = b - a;
                rvv_pkg::op_and: res[e*rvv_pkg::sew +: rvv_pkg::sew] = b & a;
                rvv_pkg::op_or:  res[e*rvv_pkg::sew +: rvv_pkg::sew] = b | a;
                rvv_pkg::op_xor: res[e*rvv_pkg::sew +: rvv_pkg::sew] = b ^ a;
                default:         res[e*rvv_pkg::sew +: rvv_pkg::sew] = b + a;
            endcase
        end
        return res;
    endfunction

    assign lane_uop[0] = rs.data0;
    assign lane_uop[1] = rs.data1;

    // Drain whatever the station holds, up to two
    assign pop[0]  = !rs.empty;
    assign pop[1]  = pop[0] && !rs.one_left;
    assign rs.pop0 = pop[0];
    assign rs.pop1 = pop[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= '0;
        end else begin
            wb_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < rvv_pkg::issue_lanes; l++) begin
            if (pop[l]) begin
                wb_pc[l]      <= lane_uop[l].uop.pc;
                wb_vd[l]      <= lane_uop[l].uop.vd;
                wb_illegal[l] <= lane_uop[l].uop.illegal;
                wb_data[l]    <= alu_calc(lane_uop[l].uop.op, lane_uop[l].vs1_data,
                                          lane_uop[l].vs2_data);
            end
        end
    end

endmodule

/* hdl/rvv_backend.sv */
`timescale 1ns/1ps

module rvv_backend (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [1:0]                  insts_valid,
    input  rvv_pkg::cmd_t [1:0]         insts,
    output logic [1:0]                  insts_ready,
    output logic [1:0]                  rt_valid,
    output logic [1:0][31:0]            rt_pc,
    output rvv_pkg::reg_idx_t [1:0]     rt_vd,
    output rvv_pkg::vreg_t    [1:0]     rt_data,
    output logic [1:0]                  rt_illegal
);

    logic                       cq_push0;
    logic                       cq_push1;
    logic                       uq_push0;
    logic                       uq_push1;
    logic                       uq_free0;
    logic                       uq_free1;
    rvv_pkg::uop_t              uq_data0;
    rvv_pkg::uop_t              uq_data1;
    rvv_pkg::reg_idx_t [3:0]    rd_idx;
    rvv_pkg::vreg_t    [3:0]    rd_data;
    logic                       rs_push0;
    logic                       rs_push1;
    logic                       rs_free0;
    logic                       rs_free1;
    rvv_pkg::rs_uop_t           rs_data0;
    rvv_pkg::rs_uop_t           rs_data1;
    logic [1:0]                 wb_write;

    queue_rd_if #(.payload_t(rvv_pkg::cmd_t))    cq_rd ();
    queue_rd_if #(.payload_t(rvv_pkg::uop_t))    uq_rd ();
    queue_rd_if #(.payload_t(rvv_pkg::rs_uop_t)) rs_rd ();

    // Lane 1 is only taken behind lane 0
    assign cq_push0 = insts_valid[0] & insts_ready[0];
    assign cq_push1 = insts_valid[1] & insts_ready[1] & cq_push0;

    // Illegal micro-ops retire without touching the VRF
    assign wb_write = rt_valid & ~rt_illegal;

    multi_port_fifo #(
        .payload_t  (rvv_pkg::cmd_t),
        .depth      (rvv_pkg::cq_depth)
    ) u_cmd_queue (
        .clk    (clk),
        .rst_n  (rst_n),
        .push0  (cq_push0),
        .push1  (cq_push1),
        .data0  (insts[0]),
        .data1  (insts[1]),
        .free0  (insts_ready[0]),
        .free1  (insts_ready[1]),
        .rd     (cq_rd)
    );

    rvv_decode u_decode (
        .cq     (cq_rd),
        .free0  (uq_free0),
        .free1  (uq_free1),
        .push0  (uq_push0),
        .push1  (uq_push1),
        .data0  (uq_data0),
        .data1  (uq_data1)
    );

    multi_port_fifo #(
        .payload_t  (rvv_pkg::uop_t),
        .depth      (rvv_pkg::uq_depth)
    ) u_uop_queue (
        .clk    (clk),
        .rst_n  (rst_n),
        .push0  (uq_push0),
        .push1  (uq_push1),
        .data0  (uq_data0),
        .data1  (uq_data1),
        .free0  (uq_free0),
        .free1  (uq_free1),
        .rd     (uq_rd)
    );

    rvv_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .uq         (uq_rd),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data),
        .rs_free0   (rs_free0),
        .rs_free1   (rs_free1),
        .rs_push0   (rs_push0),
        .rs_push1   (rs_push1),
        .rs_data0   (rs_data0),
        .rs_data1   (rs_data1),
        .wb_valid   (wb_write),
        .wb_vd      (rt_vd)
    );

    multi_port_fifo #(
        .payload_t  (rvv_pkg::rs_uop_t),
        .depth      (rvv_pkg::rs_depth)
    ) u_alu_rs (
        .clk    (clk),
        .rst_n  (rst_n),
        .push0  (rs_push0),
        .push1  (rs_push1),
        .data0  (rs_data0),
        .data1  (rs_data1),
        .free0  (rs_free0),
        .free1  (rs_free1),
        .rd     (rs_rd)
    );

    rvv_alu u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs         (rs_rd),
        .wb_valid   (rt_valid),
        .wb_pc      (rt_pc),
        .wb_vd      (rt_vd),
        .wb_data    (rt_data),
        .wb_illegal (rt_illegal)
    );

    rvv_vrf u_vrf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data),
        .wr_en      (wb_write),
        .wr_idx     (rt_vd),
        .wr_data    (rt_data)
    );

endmodule

/* hdl/rvv_decode.sv */
`timescale 1ns/1ps

module rvv_decode (
    queue_rd_if.consumer    cq,
    input  logic            free0,
    input  logic            free1,
    output logic            push0,
    output logic            push1,
    output rvv_pkg::uop_t   data0,
    output rvv_pkg::uop_t   data1
);

    function automatic rvv_pkg::uop_t decode_cmd(input rvv_pkg::cmd_t cmd);
        rvv_pkg::uop_t u;
        logic [5:0]    funct6;
        logic          op_ok;
        funct6    = cmd.inst[rvv_pkg::funct6_msb:rvv_pkg::funct6_lsb];
        u.pc      = cmd.pc;
        u.vd      = cmd.inst[rvv_pkg::vd_msb:rvv_pkg::vd_lsb];
        u.vs1     = cmd.inst[rvv_pkg::vs1_msb:rvv_pkg::vs1_lsb];
        u.vs2     = cmd.inst[rvv_pkg::vs2_msb:rvv_pkg::vs2_lsb];
        op_ok     = 1'b1;
        case (funct6)
            rvv_pkg::funct6_add: u.op = rvv_pkg::op_add;
            rvv_pkg::funct6_sub: u.op = rvv_pkg::op_sub;
            rvv_pkg::funct6_and: u.op = rvv_pkg::op_and;
            rvv_pkg::funct6_or:  u.op = rvv_pkg::op_or;
            rvv_pkg::funct6_xor: u.op = rvv_pkg::op_xor;
            default: begin
                u.op  = rvv_pkg::op_add;
                op_ok = 1'b0;
            end
        endcase
        // Only OPIVV integer forms are handled
        u.illegal = !op_ok
            || (cmd.inst[rvv_pkg::opcode_msb:rvv_pkg::opcode_lsb] != rvv_pkg::opcode_vec)
            || (cmd.inst[rvv_pkg::funct3_msb:rvv_pkg::funct3_lsb] != rvv_pkg::funct3_opivv);
        return u;
    endfunction

    // Take only what the micro-op queue can absorb this cycle
    assign cq.pop0 = !cq.empty && free0;
    assign cq.pop1 = cq.pop0 && !cq.one_left && free1;

    assign push0 = cq.pop0;
    assign push1 = cq.pop1;
    assign data0 = decode_cmd(cq.data0);
    assign data1 = decode_cmd(cq.data1);

endmodule

/* hdl/rvv_vrf.sv */
`timescale 1ns/1ps

module rvv_vrf (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rvv_pkg::reg_idx_t [3:0]     rd_idx,
    output rvv_pkg::vreg_t    [3:0]     rd_data,
    input  logic [1:0]                  wr_en,
    input  rvv_pkg::reg_idx_t [1:0]     wr_idx,
    input  rvv_pkg::vreg_t    [1:0]     wr_data
);

    rvv_pkg::vreg_t regs [rvv_pkg::num_vreg];

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rd_data[r] = regs[rd_idx[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rvv_pkg::num_vreg; i++) begin
                regs[i] <= rvv_pkg::vrf_init(i);
            end
        end else begin
            for (int w = 0; w < rvv_pkg::issue_lanes; w++) begin
                if (wr_en[w]) begin
                    regs[wr_idx[w]] <= wr_data[w];
                end
            end
        end
    end

    // The scoreboard upstream keeps the write ports apart
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en[0] && wr_en[1] |-> wr_idx[0] != wr_idx[1]);

endmodule

/* tb/rvv_ref_model.svh */
`ifndef RVV_REF_MODEL_SVH
`define RVV_REF_MODEL_SVH

typedef struct {
    logic [31:0]       pc;
    rvv_pkg::reg_idx_t vd;
    rvv_pkg::vreg_t    data;
    logic              illegal;
} exp_rt_t;

rvv_pkg::vreg_t ref_regs [32];
exp_rt_t        exp_q [$];

// Byte j of register i starts as 16*i + j
function automatic void init_ref_regs();
    for (int i = 0; i < 32; i++) begin
        for (int j = 0; j < 16; j++) begin
            ref_regs[i][j*8 +: 8] = 8'((16 * i + j) % 256);
        end
    end
endfunction

function automatic logic inst_illegal(input logic [31:0] inst);
    logic [5:0] f6;
    logic       f6_ok;
    f6    = inst[31:26];
    f6_ok = (f6 == 6'b000000) || (f6 == 6'b000010) || (f6 == 6'b001001)
        || (f6 == 6'b001010) || (f6 == 6'b001011);
    return !f6_ok || (inst[6:0] != 7'b1010111) || (inst[14:12] != 3'b000);
endfunction

// vs2 is the left operand, so sub gives vs2 - vs1
function automatic rvv_pkg::vreg_t elementwise(input logic [5:0] f6,
                                               input rvv_pkg::vreg_t vs2,
                                               input rvv_pkg::vreg_t vs1);
    rvv_pkg::vreg_t res;
    logic [7:0]     a;
    logic [7:0]     b;
    for (int e = 0; e < 16; e++) begin
        a = vs2[e*8 +: 8];
        b = vs1[e*8 +: 8];
        case (f6)
            6'b000000: res[e*8 +: 8] = a + b;
            6'b000010: res[e*8 +: 8] = a - b;
            6'b001001: res[e*8 +: 8] = a & b;
            6'b001010: res[e*8 +: 8] = a | b;
            default:   res[e*8 +: 8] = a ^ b;
        endcase
    end
    return res;
endfunction

function automatic void accept_inst(input logic [31:0] pc, input logic [31:0] inst);
    exp_rt_t item;
    item.pc      = pc;
    item.vd      = inst[11:7];
    item.illegal = inst_illegal(inst);
    item.data    = elementwise(inst[31:26], ref_regs[inst[24:20]], ref_regs[inst[19:15]]);
    if (!item.illegal) begin
        ref_regs[item.vd] = item.data;
    end
    exp_q.push_back(item);
endfunction

`endif

/* tb/tb_rvv_backend.sv */
`timescale 1ns/1ps

module tb_rvv_backend;

    typedef struct {
        int          test;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [1:0]  valid;
        int          gap;
    } entry_t;

    logic                    clk;
    logic                    rst_n;
    logic [1:0]              insts_valid;
    rvv_pkg::cmd_t [1:0]     insts;
    logic [1:0]              insts_ready;
    logic [1:0]              rt_valid;
    logic [1:0][31:0]        rt_pc;
    rvv_pkg::reg_idx_t [1:0] rt_vd;
    rvv_pkg::vreg_t [1:0]    rt_data;
    logic [1:0]              rt_illegal;

    entry_t      table_q [$];
    string       test_names [5];
    int          seed = 40;
    int          errors = 0;
    int          n_checks = 0;
    int          cycle = 0;
    int          limit = 0;
    int          cur_test = 0;
    int          r0_drop = -1;
    int          r1_drop = -1;
    bit          after_reset_seen = 0;
    logic [31:0] next_pc = 32'h0000_1000;

    `include "rvv_ref_model.svh"

    rvv_backend DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts       (insts),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid),
        .rt_pc       (rt_pc),
        .rt_vd       (rt_vd),
        .rt_data     (rt_data),
        .rt_illegal  (rt_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_vreg(input string name, input rvv_pkg::vreg_t exp,
                              input rvv_pkg::vreg_t act);
        n_checks++;
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input rvv_pkg::reg_idx_t exp,
                             input rvv_pkg::reg_idx_t act);
        n_checks++;
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] encode_inst(input logic [5:0] f6, input logic [2:0] f3,
                                                input int vd, input int vs2, input int vs1);
        return {f6, 1'b1, 5'(vs2), 5'(vs1), f3, 5'(vd), 7'b1010111};
    endfunction

    function automatic logic [31:0] vv_inst(input logic [5:0] f6, input int vd,
                                            input int vs2, input int vs1);
        return encode_inst(f6, 3'b000, vd, vs2, vs1);
    endfunction

    function automatic void add_entry(input int test, input logic [31:0] i0,
                                      input logic [31:0] i1, input logic [1:0] valid,
                                      input int gap);
        entry_t e;
        e.test  = test;
        e.inst0 = i0;
        e.inst1 = i1;
        e.valid = valid;
        e.gap   = gap;
        table_q.push_back(e);
    endfunction

    function automatic logic [5:0] pick_funct6(input int k);
        case (k)
            0:       return 6'b000000;
            1:       return 6'b000010;
            2:       return 6'b001001;
            3:       return 6'b001010;
            default: return 6'b001011;
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        int k;
        int vs2;
        int vs1;
        k   = $unsigned($random(seed)) % 5;
        vs2 = $unsigned($random(seed)) % 32;
        vs1 = $unsigned($random(seed)) % 32;
        // Shared destination keeps dispatch slower than the input
        return vv_inst(pick_funct6(k), 8, vs2, vs1);
    endfunction

    function automatic void build_table();
        add_entry(1, vv_inst(6'b001010, 3, 3, 3), 32'h0, 2'b01, 2);
        // Operands near the top of the pattern make add and sub wrap
        add_entry(2, vv_inst(6'b000000, 10, 31, 20), vv_inst(6'b000010, 11, 1, 30), 2'b11, 1);
        add_entry(2, vv_inst(6'b001001, 12, 25, 26), vv_inst(6'b001010, 13, 17, 18), 2'b11, 1);
        add_entry(2, vv_inst(6'b001011, 14, 21, 22), 32'h0, 2'b01, 4);
        add_entry(3, vv_inst(6'b000000, 4, 2, 3), vv_inst(6'b001011, 5, 4, 1), 2'b11, 0);
        add_entry(3, vv_inst(6'b000010, 6, 5, 4), vv_inst(6'b001010, 4, 6, 5), 2'b11, 0);
        add_entry(3, vv_inst(6'b000000, 6, 4, 6), 32'h0, 2'b01, 3);
        // One single command first so the queue passes through seven entries
        add_entry(4, random_inst(), 32'h0, 2'b01, 0);
        for (int n = 0; n < 16; n++) begin
            add_entry(4, random_inst(), random_inst(), 2'b11, (n == 15) ? 4 : 0);
        end
        add_entry(5, vv_inst(6'b111111, 9, 2, 1), encode_inst(6'b000000, 3'b011, 16, 2, 1),
                  2'b11, 2);
        add_entry(5, vv_inst(6'b001010, 19, 9, 9), vv_inst(6'b001010, 20, 16, 16), 2'b11, 2);
    endfunction

    task automatic drive_entry(input entry_t e);
        logic [31:0] pend [$];
        int          n_acc;
        pend.push_back(e.inst0);
        if (e.valid[1]) begin
            pend.push_back(e.inst1);
        end
        while (pend.size() != 0) begin
            @(posedge clk);
            #1;
            insts_valid[0] = 1'b1;
            insts_valid[1] = (pend.size() > 1);
            insts[0]       = '{pc: next_pc, inst: pend[0]};
            insts[1]       = '{pc: next_pc + 32'd4, inst: (pend.size() > 1) ? pend[1] : 32'h0};
            @(negedge clk);
            n_acc = 0;
            if (insts_ready[0]) begin
                accept_inst(next_pc, pend[0]);
                n_acc = 1;
                if (insts_valid[1] && insts_ready[1]) begin
                    accept_inst(next_pc + 32'd4, pend[1]);
                    n_acc = 2;
                end
            end
            repeat (n_acc) void'(pend.pop_front());
            next_pc = next_pc + 32'(4 * n_acc);
        end
        if (e.gap > 0) begin
            @(posedge clk);
            #1;
            insts_valid = 2'b00;
            repeat (e.gap - 1) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("Timeout after %0d cycles, %0d expected retires never arrived",
                     cycle, exp_q.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    always @(negedge clk) begin
        exp_rt_t exp_item;
        if (!rst_n) begin
            if (cycle >= 2) begin
                check_bit("rt_valid[0] in reset", 1'b0, rt_valid[0]);
                check_bit("rt_valid[1] in reset", 1'b0, rt_valid[1]);
                check_bit("insts_ready[0] in reset", 1'b0, insts_ready[0]);
                check_bit("insts_ready[1] in reset", 1'b0, insts_ready[1]);
            end
        end else begin
            if (!after_reset_seen) begin
                after_reset_seen = 1;
                check_bit("rt_valid[0] after reset", 1'b0, rt_valid[0]);
                check_bit("rt_valid[1] after reset", 1'b0, rt_valid[1]);
                // Command queue opens only on the first edge out of reset
                check_bit("insts_ready[0] after reset", 1'b0, insts_ready[0]);
                check_bit("insts_ready[1] after reset", 1'b0, insts_ready[1]);
            end
            if (!insts_ready[0]) begin
                check_bit("insts_ready[1] with lane 0 full", 1'b0, insts_ready[1]);
            end
            if (cur_test == 4) begin
                if (!insts_ready[1] && r1_drop < 0) begin
                    r1_drop = cycle;
                end
                if (!insts_ready[0] && r0_drop < 0) begin
                    r0_drop = cycle;
                end
            end
            for (int l = 0; l < 2; l++) begin
                if (rt_valid[l]) begin
                    if (exp_q.size() == 0) begin
                        $display("Lane %0d retired at %0t with nothing outstanding", l, $time);
                        errors++;
                    end else begin
                        exp_item = exp_q.pop_front();
                        check_pc($sformatf("rt_pc[%0d]", l), exp_item.pc, rt_pc[l]);
                        check_idx($sformatf("rt_vd[%0d]", l), exp_item.vd, rt_vd[l]);
                        check_bit($sformatf("rt_illegal[%0d]", l), exp_item.illegal,
                                  rt_illegal[l]);
                        if (!exp_item.illegal) begin
                            check_vreg($sformatf("rt_data[%0d]", l), exp_item.data, rt_data[l]);
                        end
                    end
                end
            end
        end
    end

    initial begin
        int err_start;
        rst_n       = 1'b0;
        insts_valid = 2'b00;
        insts       = '0;
        test_names  = '{"reset and identity", "five operations", "dependent chain",
                        "dual-lane burst", "illegal encodings"};
        init_ref_regs();
        build_table();
        limit = 60 * table_q.size() + 200;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 1; t <= 5; t++) begin
            cur_test  = t;
            err_start = errors;
            foreach (table_q[i]) begin
                if (table_q[i].test == t) begin
                    drive_entry(table_q[i]);
                end
            end
            while (exp_q.size() != 0) @(negedge clk);
            if (t == 4) begin
                if (r0_drop < 0 || r1_drop < 0) begin
                    $display("The burst never filled the command queue");
                    errors++;
                end else if (r1_drop >= r0_drop) begin
                    $display("insts_ready[1] did not drop before insts_ready[0]");
                    errors++;
                end
            end
            $display("Test %0d (%s) finished with %0d errors", t, test_names[t-1],
                     errors - err_start);
        end
        $display("Summary: 5 tests, %0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tb
common/rvv_pkg.sv
common/queue_rd_if.sv
hdl/multi_port_fifo.sv
hdl/rvv_decode.sv
dispatch/rvv_dispatch.sv
hdl/rvv_vrf.sv
hdl/rvv_alu.sv
hdl/rvv_backend.sv
tb/tb_rvv_backend.sv
